//--- hdl/wb_arb_pkg.sv
// ----------------------------------------------------------
// Shared definitions for the four-master Wishbone bus
// Bus widths, arbitration scheme encoding and the
// request and response structs
// ----------------------------------------------------------
`default_nettype none

package wb_arb_pkg;

  // Scheme encodings are defined for exactly four masters
  localparam int NUM_MASTERS = 4;

  localparam int ADDR_W = 10;  // Word address
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Values 6 and 7 are left unnamed and park the bus
  typedef enum logic [2:0] {
    fixed_p0    = 3'd0,
    fixed_p1    = 3'd1,
    fixed_p2    = 3'd2,
    fixed_p3    = 3'd3,
    round_robin = 3'd4,
    pn_random   = 3'd5
  } arb_scheme_e;

  // Master to slave, 49 bits
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  // Slave to master, 33 bits
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/pn_seq_gen.sv
// ----------------------------------------------------------
// Three-stage LFSR, 7-state sequence
// Upper two bits name the favored master
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module pn_seq_gen (
  input  logic       clk,
  input  logic       rst_n,
  output logic [1:0] rand_idx
);

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  assign fb = s1 ^ s3;  // Feedback tap

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  assign rand_idx = {s3, s2};

endmodule

`default_nettype wire

//--- hdl/bus_arbiter.sv
// ----------------------------------------------------------
// Four-way bus arbiter with fixed, round-robin and
// pseudo-random schemes; grant held for the owner's cycle
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module bus_arbiter import wb_arb_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [NUM_MASTERS-1:0] req,
  input  arb_scheme_e            arb_type,
  output logic [NUM_MASTERS-1:0] gnt
);

  logic [1:0]             rand_idx;
  logic [1:0]             last_idx;  // Round-robin pointer
  logic [NUM_MASTERS-1:0] pick_fixed [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] pick_rr;
  logic [NUM_MASTERS-1:0] pick_pn;
  logic [NUM_MASTERS-1:0] pick_sel;
  logic                   bus_free;

  // Favored master first, then ascending index
  function automatic logic [NUM_MASTERS-1:0] fixed_pick(
    input logic [NUM_MASTERS-1:0] r,
    input logic [1:0]             fav
  );
    logic [NUM_MASTERS-1:0] pick;
    logic                   found;
    pick  = '0;
    found = 1'b0;
    if (r[fav]) begin
      pick[fav] = 1'b1;
      found     = 1'b1;
    end
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (!found && r[i]) begin
        pick[i] = 1'b1;
        found   = 1'b1;
      end
    end
    return pick;
  endfunction

  // Search upward from the master after the last owner
  function automatic logic [NUM_MASTERS-1:0] rr_pick(
    input logic [NUM_MASTERS-1:0] r,
    input logic [1:0]             ptr
  );
    logic [NUM_MASTERS-1:0] pick;
    logic                   found;
    logic [1:0]             idx;
    pick  = '0;
    found = 1'b0;
    for (int k = 1; k <= NUM_MASTERS; k++) begin
      idx = ptr + 2'(k);  // Wraps modulo 4
      if (!found && r[idx]) begin
        pick[idx] = 1'b1;
        found     = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic logic [1:0] onehot_idx(input logic [NUM_MASTERS-1:0] oh);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (oh[i])
        idx = 2'(i);
    end
    return idx;
  endfunction

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_idx (rand_idx)
  );

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      pick_fixed[i] = fixed_pick(req, 2'(i));
    end
  end

  assign pick_rr = rr_pick(req, last_idx);
  assign pick_pn = fixed_pick(req, rand_idx);

  always_comb begin
    case (arb_type)
      fixed_p0:    pick_sel = pick_fixed[0];
      fixed_p1:    pick_sel = pick_fixed[1];
      fixed_p2:    pick_sel = pick_fixed[2];
      fixed_p3:    pick_sel = pick_fixed[3];
      round_robin: pick_sel = pick_rr;
      pn_random:   pick_sel = pick_pn;
      default:     pick_sel = '0;  // Park
    endcase
  end

  // Idle bus, or the owner has dropped cyc
  assign bus_free = ~|(gnt & req);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt      <= '0;
      last_idx <= 2'd3;  // Master 0 goes first
    end else if (bus_free) begin
      gnt <= pick_sel;
      if (|pick_sel)
        last_idx <= onehot_idx(pick_sel);
    end
  end

endmodule

`default_nettype wire

//--- hdl/wb_master_mux.sv
// ----------------------------------------------------------
// Wishbone master multiplexer
// Owner's request to the slave, ack back to the owner only
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module wb_master_mux import wb_arb_pkg::*; (
  input  logic    [NUM_MASTERS-1:0] gnt,
  input  wb_req_t [NUM_MASTERS-1:0] m_req,
  output wb_rsp_t [NUM_MASTERS-1:0] m_rsp,
  output wb_req_t                   s_req,
  input  wb_rsp_t                   s_rsp
);

  // Grant is one-hot or zero, so at most one term passes
  always_comb begin
    s_req = '0;  // No owner drives an idle bus
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (gnt[i])
        s_req = m_req[i];
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_rsp[i].ack = s_rsp.ack & gnt[i];
      m_rsp[i].dat = s_rsp.dat;  // Read data broadcast
    end
  end

endmodule

`default_nettype wire

//--- hdl/wb_ram_slave.sv
// ----------------------------------------------------------
// Wishbone classic RAM slave
// Byte-lane writes, registered single-cycle acknowledge
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module wb_ram_slave import wb_arb_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t s_req,
  output wb_rsp_t s_rsp
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] rd_dat;
  logic [AW-1:0]     word_idx;
  logic              ack;
  logic              take;

  assign word_idx = s_req.adr[AW-1:0];  // Upper bits wrap

  // No new transfer in the ack cycle itself
  assign take = s_req.cyc & s_req.stb & ~ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ack <= 1'b0;
    else
      ack <= take;
  end

  // Write commits and read data lands on the acknowledging edge
  always_ff @(posedge clk) begin
    if (take) begin
      if (s_req.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (s_req.sel[b])
            mem[word_idx][8*b +: 8] <= s_req.dat[8*b +: 8];
        end
      end else begin
        rd_dat <= mem[word_idx];
      end
    end
  end

  assign s_rsp.ack = ack;
  assign s_rsp.dat = rd_dat;

endmodule

`default_nettype wire

//--- hdl/wb_shared_bus.sv
// ----------------------------------------------------------
// Shared Wishbone bus top level
// Arbiter, master multiplexer and one RAM slave
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module wb_shared_bus import wb_arb_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  arb_scheme_e               arb_type,
  input  wb_req_t [NUM_MASTERS-1:0] m_req,
  output wb_rsp_t [NUM_MASTERS-1:0] m_rsp,
  output logic    [NUM_MASTERS-1:0] gnt
);

  logic [NUM_MASTERS-1:0] cyc_vec;  // Bus requests
  wb_req_t                s_req;
  wb_rsp_t                s_rsp;

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      cyc_vec[i] = m_req[i].cyc;
    end
  end

  bus_arbiter u_bus_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (cyc_vec),
    .arb_type (arb_type),
    .gnt      (gnt)
  );

  wb_master_mux u_wb_master_mux (
    .gnt   (gnt),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  wb_ram_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_wb_ram_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

endmodule

`default_nettype wire

//--- bench/tb_wb_shared_bus.sv
// ----------------------------------------------------------
// Testbench for the shared Wishbone bus
// LFSR stimulus, four master drivers, arbitration model,
// memory model and checks
// ----------------------------------------------------------
`default_nettype none
`timescale 1ns/100ps

module tb_wb_shared_bus import wb_arb_pkg::*; ();

  localparam int          MEM_WORDS = 256;
  localparam int          ACK_TMO   = 200;
  localparam logic [31:0] SEED      = 32'h260e_d8ae;
  localparam logic [31:0] POLY      = 32'h8020_0003;

  logic                      clk;
  logic                      rst_n;
  arb_scheme_e               arb_type;
  wb_req_t [NUM_MASTERS-1:0] m_req;
  wb_rsp_t [NUM_MASTERS-1:0] m_rsp;
  logic    [NUM_MASTERS-1:0] gnt;

  logic [DATA_W-1:0] mem_model [64];  // Masters stay within 64 words
  logic [31:0]       lfsr_st [5];     // One stream per master, one for schemes
  logic [3:0]        exp_gnt;
  logic [1:0]        mdl_ptr;
  logic              pn_s1;
  logic              pn_s2;
  logic              pn_s3;
  string             exp_name;
  logic [3:0]        prev_gnt;
  logic [3:0]        prev_ack;
  int                rr_cnt;
  logic [3:0]        fill_done;
  logic [3:0]        drv_done;
  logic              rnd_go;
  logic              stop;
  int                chk_cnt;
  int                err_cnt;
  int                tmo_cnt;

  wb_shared_bus #(
    .MEM_WORDS (MEM_WORDS)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .arb_type (arb_type),
    .m_req    (m_req),
    .m_rsp    (m_rsp),
    .gnt      (gnt)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int src, input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr_st[src][0];
      lfsr_st[src] = lfsr_st[src] >> 1;
      if (b)
        lfsr_st[src] = lfsr_st[src] ^ POLY;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {6'h2a, a, 6'h15, a};
  endfunction

  function automatic string scheme_name(input logic [2:0] s);
    if (s <= 3'd3)
      return "fixed_gnt";
    else if (s == 3'd4)
      return "rr_gnt";
    else if (s == 3'd5)
      return "pn_gnt";
    return "park_gnt";
  endfunction

  // Expected owner from the scheme rules
  function automatic logic [3:0] model_pick(input logic [2:0] scheme, input logic [3:0] r,
                                            input logic [1:0] ptr, input logic [1:0] pn_idx);
    int         order [4];
    int         fav;
    int         j;
    logic       found;
    logic [3:0] pick;
    pick  = '0;
    found = 1'b0;
    fav   = (scheme == 3'd5) ? int'(pn_idx) : int'(scheme[1:0]);
    order[0] = fav;
    j = 1;
    for (int i = 0; i < 4; i++) begin
      if (scheme == 3'd4) begin
        order[i] = (int'(ptr) + 1 + i) % 4;
      end else if (i != fav) begin
        order[j] = i;
        j++;
      end
    end
    if (scheme <= 3'd5) begin
      for (int k = 0; k < 4; k++) begin
        if (!found && r[order[k]]) begin
          pick  = 4'b0001 << order[k];
          found = 1'b1;
        end
      end
    end
    return pick;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("ERR %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // One classic transfer, held until ack
  task automatic do_transfer(input int m, input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                             input logic keep, output logic ok);
    wb_req_t req;
    int      n;
    logic    got;
    req.cyc  = 1'b1;
    req.stb  = 1'b1;
    req.we   = we;
    req.adr  = adr;
    req.dat  = dat;
    req.sel  = sel;
    m_req[m] = req;
    n   = 0;
    got = 1'b0;
    while (!got && n < ACK_TMO) begin
      @(negedge clk);
      got = m_rsp[m].ack;
      n++;
    end
    ok = got;
    if (!got) begin
      $display("Timeout: master %0d got no ack within %0d cycles", m, ACK_TMO);
      tmo_cnt++;
    end else if (we) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel[b])
          mem_model[adr[5:0]][8*b +: 8] = dat[8*b +: 8];
      end
    end else begin
      check("read_data", mem_model[adr[5:0]], m_rsp[m].dat);
    end
    @(posedge clk);
    #1;
    if (!keep || !got)
      m_req[m] = '0;
  endtask

  task automatic rand_transfer(input int m, input logic keep, output logic ok);
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    we  = rand_bits(m, 1) != 0;
    adr = ADDR_W'(rand_bits(m, 6));
    dat = rand_bits(m, 32);
    sel = SEL_W'(rand_bits(m, 4));
    do_transfer(m, we, adr, dat, sel, keep, ok);
  endtask

  task automatic run_master(input int m);
    logic ok;
    logic keep;
    int   n;
    repeat (10) @(posedge clk);
    #1;
    // Each master fills every fourth word
    for (int k = 0; k < 16; k++) begin
      do_transfer(m, 1'b1, ADDR_W'(m + 4*k), fill_word(ADDR_W'(m + 4*k)), 4'hf, 1'b0, ok);
      @(posedge clk);
      #1;
    end
    fill_done[m] = 1'b1;
    n = 0;
    while (!rnd_go && n < 2000) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rnd_go) begin
      $display("Timeout: master %0d never saw the random phase start", m);
      tmo_cnt++;
    end
    while (!stop) begin
      if (rand_bits(m, 4) == 0) begin
        keep = rand_bits(m, 2) == 0;  // Hold cyc for a second transfer
        rand_transfer(m, keep, ok);
        if (ok && keep)
          rand_transfer(m, 1'b0, ok);
      end
      @(posedge clk);
      #1;
    end
    drv_done[m] = 1'b1;
  endtask

  initial begin
    fork
      run_master(0);
      run_master(1);
      run_master(2);
      run_master(3);
    join
  end

  // Inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin : bus_monitor
    logic [3:0] cyc;
    logic [3:0] ack_vec;
    logic [3:0] nxt;
    if (rst_n) begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
        cyc[i]     = m_req[i].cyc;
        ack_vec[i] = m_rsp[i].ack;
      end
      check(exp_name, 32'(exp_gnt), 32'(gnt));
      check("ack_owner", 0, 32'(ack_vec & ~exp_gnt));
      check("ack_len", 0, 32'(ack_vec & prev_ack));
      // Fill phase keeps all four masters busy under round robin
      if (!rnd_go && gnt != 0 && gnt != prev_gnt) begin
        check("rr_order", 32'(1) << (rr_cnt % 4), 32'(gnt));
        rr_cnt++;
      end
      prev_gnt = gnt;
      prev_ack = ack_vec;
      if ((exp_gnt & cyc) == 0) begin
        nxt      = model_pick(arb_type, cyc, mdl_ptr, {pn_s3, pn_s2});
        exp_name = scheme_name(arb_type);
        for (int i = 0; i < NUM_MASTERS; i++) begin
          if (nxt[i])
            mdl_ptr = 2'(i);
        end
        exp_gnt = nxt;
      end else begin
        exp_name = "hold_gnt";
      end
      {pn_s1, pn_s2, pn_s3} = {pn_s1 ^ pn_s3, pn_s1, pn_s2};  // DUT steps at next edge
    end
  end

  initial begin : main_seq
    int         n;
    logic [2:0] sch;
    rst_n     = 1'b0;
    arb_type  = arb_scheme_e'(3'd6);
    m_req     = '0;
    exp_gnt   = '0;
    mdl_ptr   = 2'd3;
    {pn_s1, pn_s2, pn_s3} = 3'b100;
    exp_name  = "reset_gnt";
    prev_gnt  = '0;
    prev_ack  = '0;
    rr_cnt    = 0;
    fill_done = '0;
    drv_done  = '0;
    rnd_go    = 1'b0;
    stop      = 1'b0;
    chk_cnt   = 0;
    err_cnt   = 0;
    tmo_cnt   = 0;
    for (int i = 0; i < 5; i++)
      lfsr_st[i] = SEED ^ (32'h9e37_79b9 * 32'(i));
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (24) @(posedge clk);  // Parked while every cyc rises
    #1 arb_type = round_robin;
    n = 0;
    while (fill_done != 4'hf && n < 1000) begin
      @(posedge clk);
      n++;
    end
    if (fill_done != 4'hf) begin
      $display("Timeout: the memory fill did not finish");
      tmo_cnt++;
    end
    #2 rnd_go = 1'b1;
    @(posedge clk);
    for (int p = 0; p < 40; p++) begin
      #1 sch = 3'(rand_bits(4, 3));
      arb_type = arb_scheme_e'(sch);
      repeat ((sch > 3'd5) ? 16 : 48) @(posedge clk);  // Short park phases
    end
    #2 stop = 1'b1;
    n = 0;
    while (drv_done != 4'hf && n < 500) begin
      @(posedge clk);
      n++;
    end
    if (drv_done != 4'hf) begin
      $display("Timeout: the master drivers did not stop");
      tmo_cnt++;
    end
    repeat (4) @(posedge clk);
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_shared_bus.f
hdl/wb_arb_pkg.sv
hdl/pn_seq_gen.sv
hdl/bus_arbiter.sv
hdl/wb_master_mux.sv
hdl/wb_ram_slave.sv
hdl/wb_shared_bus.sv
bench/tb_wb_shared_bus.sv

//--- Makefile
# Verilator build and run for the shared Wishbone bus

VERILATOR ?= verilator
FILELIST  ?= wb_shared_bus.f
TOP       ?= tb_wb_shared_bus
RTL_TOP   ?= wb_shared_bus
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD) -o V$(TOP)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
